//--- Bender.yml
package:
  name: mips_reg_decode

sources:
  - hw/mipsPkg.sv
  - hw/instrDecode.sv
  - hw/regControlGen.sv
  - hw/regAccessStage.sv
  - hw/regFile.sv
  - hw/mipsRegDecode.sv
  - target: test
    files:
      - dv/tbClock.sv
      - dv/mipsRegDecode_assert.sv
      - dv/tbMipsRegDecode.sv

//--- dv/mipsRegDecode_assert.sv
module mipsRegDecodeAssert (
	input logic              clk,
	input logic              rst,
	input logic              instrValid,
	input logic              accessValid,
	input mipsPkg::regAccess access,
	input logic [31:0]       rdData1
);

import mipsPkg::*;

// Fixed two-cycle pipeline.
validLatency: assert property (@(posedge clk) disable iff (rst)
	instrValid |-> ##2 accessValid)
	else $error("accessValid did not follow instrValid after two cycles");

noSpuriousValid: assert property (@(posedge clk) disable iff (rst)
	accessValid |-> $past(instrValid, 2))
	else $error("accessValid high without instrValid two cycles before");

linkWritesR31: assert property (@(posedge clk) disable iff (rst)
	(accessValid && access.writeDataSource == WD_PC) |-> (access.writeAddr == 5'd31))
	else $error("pc write-back aimed at a register other than r31");

zeroRegRead: assert property (@(posedge clk) disable iff (rst)
	(access.port1Addr == 5'd0) |-> (rdData1 == 32'h0))
	else $error("r0 read on port 1 returned a non-zero value");

endmodule

bind mipsRegDecode mipsRegDecodeAssert assert_i (.*);

//--- dv/tbClock.sv
module tbClock (
	output logic clk,
	output logic rst
);

initial begin
	clk = 1'b0;
	forever #2 clk = ~clk; // Period 4.
end

// Reset held for five rising edges.
initial begin
	rst = 1'b1;
	repeat (5) @(posedge clk);
	#1 rst = 1'b0;
end

endmodule

//--- dv/tbMipsRegDecode.sv
module tbMipsRegDecode;

import mipsPkg::*;

typedef struct packed {
	regAccess    acc;
	logic [31:0] alu;
	logic [31:0] mem;
	logic [31:0] pc;
	logic [31:0] sentCycle;
} expectItem;

logic        clk;
logic        rst;
logic        instrValid;
mipsInstr    instr;
logic [31:0] aluResult;
logic [31:0] memData;
logic [31:0] linkPc;
logic        accessValid;
regAccess    access;
logic [31:0] rdData1;
logic [31:0] rdData2;

expectItem   expQ[$];
logic [31:0] mirror [32]; // Predicted register contents.
logic [4:0]  lastWrite;
logic [31:0] cycleNo;
integer      seed;

logic [5:0] shiftFns [6] = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};
logic [5:0] aluFns [5] = '{6'h20, 6'h22, 6'h24, 6'h25, 6'h2A};
logic [5:0] loadOps [6] = '{OP_LB, OP_LH, OP_LWL, OP_LW, OP_LBU, OP_LHU};
logic [5:0] noWriteOps [8] = '{OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_REGIMM, OP_SB, OP_SH, OP_SW};
logic [5:0] opTable [25] = '{OP_SPECIAL, OP_REGIMM, OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_BLEZ,
	OP_BGTZ, OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LB,
	OP_LH, OP_LWL, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW};

tbClock clock_i (
	.clk (clk),
	.rst (rst)
);

mipsRegDecode #(
	.REG_COUNT (32)
) dut_i (
	.clk         (clk),
	.rst         (rst),
	.instrValid  (instrValid),
	.instr       (instr),
	.aluResult   (aluResult),
	.memData     (memData),
	.linkPc      (linkPc),
	.accessValid (accessValid),
	.access      (access),
	.rdData1     (rdData1),
	.rdData2     (rdData2)
);

// Expected access plan from the opcode and funct.
function automatic regAccess expectAccess(input mipsInstr w);
	regAccess a;
	logic     isShift;
	logic     isLoad;
	logic     isLink;
	logic     noWrite;
	logic     rdDest;
	isShift = 1'b0;
	isLoad  = 1'b0;
	isLink  = 1'b0;
	noWrite = 1'b0;
	rdDest  = 1'b0;
	case (w.rType.opcode)
		OP_SPECIAL: begin
			case (w.rType.funct)
				FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV: begin
					isShift = 1'b1;
					rdDest  = 1'b1;
				end
				FN_JR:   noWrite = 1'b1;
				FN_JALR: isLink = 1'b1;
				default: rdDest = 1'b1;
			endcase
		end
		OP_J:                               noWrite = 1'b1;
		OP_JAL:                             isLink = 1'b1;
		OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ:   noWrite = 1'b1;
		OP_REGIMM: begin
			isLink  = (w.iType.rt == 5'd16) || (w.iType.rt == 5'd17);
			noWrite = !isLink;
		end
		OP_LB, OP_LH, OP_LWL, OP_LW, OP_LBU, OP_LHU: isLoad = 1'b1;
		OP_SB, OP_SH, OP_SW:                noWrite = 1'b1;
		default:                            ; // Immediates and unknown opcodes write rt.
	endcase
	a.port1Addr = isShift ? w.rType.rt : w.rType.rs;
	a.port2Addr = isShift ? w.rType.rs : w.rType.rt;
	if (isLoad)
		a.writeAddr = w.rType.rt;
	else if (isLink)
		a.writeAddr = 5'd31;
	else
		a.writeAddr = rdDest ? w.rType.rd : w.rType.rt;
	a.writeDataSource = isLoad ? WD_MEMORY : (isLink ? WD_PC : WD_ALU);
	a.writeEnable     = isLink || !noWrite;
	a.shamt           = w.rType.shamt;
	return a;
endfunction

function automatic logic [4:0] rndReg();
	logic [31:0] r;
	r = $random(seed);
	return r[4:0];
endfunction

function automatic mipsInstr rInstr(input logic [4:0] rs, input logic [4:0] rt,
	input logic [4:0] rd, input logic [4:0] shamt, input logic [5:0] funct);
	mipsInstr w;
	w.rType = '{OP_SPECIAL, rs, rt, rd, shamt, funct};
	return w;
endfunction

function automatic mipsInstr iInstr(input logic [5:0] op, input logic [4:0] rs,
	input logic [4:0] rt, input logic [15:0] imm);
	mipsInstr w;
	w.iType = '{op, rs, rt, imm};
	return w;
endfunction

function automatic mipsInstr jInstr(input logic [5:0] op, input logic [25:0] target);
	mipsInstr w;
	w.jType = '{op, target};
	return w;
endfunction

task automatic stopOnError(input string why);
	$display("%s", why);
	$display("Test failures found");
	$fatal(1, "stopped at the first error");
endtask

task automatic checkAccess(input string name, input regAccess got, input regAccess exp);
	if (got !== exp)
		stopOnError($sformatf("ERROR at time %0t: %s got %h expected %h",
			$time, name, got, exp));
endtask

task automatic checkData(input string name, input logic [31:0] got, input logic [31:0] exp);
	if (got !== exp)
		stopOnError($sformatf("ERROR at time %0t: %s got %h expected %h",
			$time, name, got, exp));
endtask

// Cycles from the strobe to accessValid.
task automatic checkLatency(input logic [31:0] sent, input logic [31:0] now);
	if (now - sent !== 32'd2)
		stopOnError($sformatf("ERROR at time %0t: accessValid latency got %0d expected 2",
			$time, now - sent));
endtask

task automatic sendInstr(input mipsInstr w);
	expectItem e;
	@(posedge clk);
	#1;
	e.acc       = expectAccess(w);
	e.alu       = $random(seed);
	e.mem       = $random(seed);
	e.pc        = $random(seed);
	e.sentCycle = cycleNo;
	instrValid = 1'b1;
	instr      = w;
	expQ.push_back(e);
	lastWrite = e.acc.writeAddr;
endtask

// Instruction followed by a store that only reads two registers.
task automatic sendAndRead(input mipsInstr w, input logic [4:0] regA, input logic [4:0] regB);
	sendInstr(w);
	sendInstr(iInstr(OP_SW, regA, regB, 16'h0));
endtask

task automatic idleCycles(input int n);
	repeat (n) begin
		@(posedge clk);
		#1;
		instrValid = 1'b0;
	end
endtask

task automatic waitReset();
	int cycles;
	cycles = 0;
	while (rst !== 1'b0 && cycles < 20) begin
		@(posedge clk);
		cycles++;
	end
	if (rst !== 1'b0)
		stopOnError("reset was never released");
endtask

task automatic checkIdle(input int n);
	repeat (n) begin
		@(posedge clk);
		#2;
		if (accessValid !== 1'b0)
			stopOnError("accessValid went high with no instruction sent");
	end
endtask

// One expectation per accessValid cycle.
initial begin : compare
	expectItem   e;
	logic [31:0] wb;
	forever begin
		@(posedge clk);
		cycleNo++;
		#1;
		if (accessValid === 1'b1) begin
			if (expQ.size() == 0) begin
				stopOnError("accessValid high with no instruction outstanding");
			end else begin
				e = expQ.pop_front();
				aluResult = e.alu;
				memData   = e.mem;
				linkPc    = e.pc;
				checkLatency(e.sentCycle, cycleNo);
				#1;
				checkAccess("access", access, e.acc);
				checkData("rdData1", rdData1, mirror[e.acc.port1Addr]);
				checkData("rdData2", rdData2, mirror[e.acc.port2Addr]);
				case (e.acc.writeDataSource)
					WD_MEMORY: wb = e.mem;
					WD_PC:     wb = e.pc;
					default:   wb = e.alu;
				endcase
				if (e.acc.writeEnable && e.acc.writeAddr != 5'd0)
					mirror[e.acc.writeAddr] = wb;
			end
		end
	end
end

initial begin
	mipsInstr    w;
	logic [31:0] pick;
	int          cycles;
	seed       = 65753;
	cycleNo    = '0;
	instrValid = 1'b0;
	instr      = '0;
	aluResult  = '0;
	memData    = '0;
	linkPc     = '0;
	lastWrite  = '0;
	for (int r = 0; r < 32; r++)
		mirror[r] = '0;
	waitReset();
	checkIdle(8);
	for (int r = 0; r < 32; r += 2)
		sendInstr(iInstr(OP_SW, 5'(r), 5'(r + 1), 16'h0)); // All registers read zero.
	idleCycles(3);
	for (int k = 0; k < 6; k++)
		sendInstr(rInstr(rndReg(), rndReg(), rndReg(), rndReg(), shiftFns[k]));
	for (int k = 0; k < 5; k++)
		sendInstr(rInstr(rndReg(), rndReg(), rndReg(), 5'd0, aluFns[k]));
	for (int k = 0; k < 6; k++) begin
		w = iInstr(loadOps[k], rndReg(), rndReg(), 16'h0040);
		sendAndRead(w, w.iType.rt, w.iType.rs);
	end
	for (int k = 0; k < 8; k++)
		sendInstr(iInstr(OP_ADDI + 6'(k), rndReg(), rndReg(), 16'h7F01));
	idleCycles(2);
	sendAndRead(jInstr(OP_JAL, 26'($random(seed))), 5'd31, 5'd0);
	sendAndRead(rInstr(rndReg(), 5'd0, rndReg(), 5'd0, FN_JALR), 5'd31, 5'd31);
	sendAndRead(iInstr(OP_REGIMM, rndReg(), RT_BLTZAL, 16'h0010), 5'd31, 5'd0);
	sendAndRead(iInstr(OP_REGIMM, rndReg(), RT_BGEZAL, 16'hFFF0), 5'd0, 5'd31);
	w = jInstr(OP_J, 26'($random(seed)));
	sendAndRead(w, w.rType.rt, w.rType.rd);
	w = rInstr(rndReg(), rndReg(), rndReg(), 5'd0, FN_JR);
	sendAndRead(w, w.rType.rt, w.rType.rd);
	for (int k = 0; k < 8; k++) begin
		w = iInstr(noWriteOps[k], rndReg(), (noWriteOps[k] == OP_REGIMM) ? 5'd0 : rndReg(),
			16'h1234);
		sendAndRead(w, w.iType.rt, 5'd31);
	end
	idleCycles(2);
	// Back-to-back random traffic.
	for (int k = 0; k < 300; k++) begin
		w    = $random(seed);
		pick = $random(seed);
		if (pick[1:0] != 2'd0)
			w.rType.opcode = opTable[$unsigned($random(seed)) % 25];
		if (pick[2])
			w.rType.rs = lastWrite;
		if (pick[5:3] == 3'd0)
			w.rType.rd = 5'd0;
		if (pick[8:6] == 3'd0)
			w.rType.rt = 5'd0;
		sendInstr(w);
	end
	idleCycles(1);
	cycles = 0;
	while (expQ.size() != 0 && cycles < 50) begin
		@(posedge clk);
		cycles++;
	end
	if (expQ.size() != 0) begin
		stopOnError("timed out waiting for the outstanding instructions");
	end else begin
		$display("All tests passed!");
		$finish;
	end
end

endmodule

//--- hw/instrDecode.sv
module instrDecode (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  instrValid,
	input  mipsPkg::mipsInstr     instr,
	output logic                  decValid,
	output mipsPkg::decodedInstr  dec
);

import mipsPkg::*;

opFunc        opf;
instrCategory cat;

always_comb begin
	opf.opcode = instr.rType.opcode;
	opf.funct  = (instr.rType.opcode == OP_SPECIAL) ? instr.rType.funct : 6'h00;
end

always_comb begin
	cat = '0;
	case (opf.opcode)
		OP_SPECIAL: begin
			case (opf.funct)
				FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV:
					cat.shift = 1'b1;
				FN_JR:
					cat.jump = 1'b1;
				FN_JALR: begin
					cat.link = 1'b1; // Writes r31.
					cat.jump = 1'b1;
				end
				default:
					cat.register = 1'b1;
			endcase
		end
		OP_J:
			cat.jump = 1'b1;
		OP_JAL: begin
			cat.link = 1'b1;
			cat.jump = 1'b1;
		end
		OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ:
			cat.branch = 1'b1;
		OP_REGIMM: begin
			cat.branch = 1'b1;
			cat.link   = (instr.iType.rt == RT_BLTZAL) || (instr.iType.rt == RT_BGEZAL);
		end
		OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
			cat.immediate = 1'b1;
		OP_LB, OP_LH, OP_LWL, OP_LW, OP_LBU, OP_LHU:
			cat.load = 1'b1;
		OP_SB, OP_SH, OP_SW:
			cat.store = 1'b1;
		default:
			cat = '0; // Unknown opcode sets no flags.
	endcase
end

always_ff @(posedge clk) begin
	if (rst)
		decValid <= 1'b0;
	else
		decValid <= instrValid;
end

always_ff @(posedge clk) begin
	if (instrValid) begin
		dec.instr    <= instr;
		dec.opFunc   <= opf;
		dec.category <= cat;
	end
end

endmodule

//--- hw/mipsPkg.sv
package mipsPkg;

// Instruction word views.
typedef struct packed {
	logic [5:0] opcode;
	logic [4:0] rs;
	logic [4:0] rt;
	logic [4:0] rd;
	logic [4:0] shamt;
	logic [5:0] funct;
} rTypeFields;

typedef struct packed {
	logic [5:0]  opcode;
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [15:0] imm;
} iTypeFields;

typedef struct packed {
	logic [5:0]  opcode;
	logic [25:0] target;
} jTypeFields;

typedef union packed {
	rTypeFields rType;
	iTypeFields iType;
	jTypeFields jType;
} mipsInstr;

typedef struct packed {
	logic [5:0] opcode;
	logic [5:0] funct; // Zero unless SPECIAL.
} opFunc;

// Flags are independent and several may be set.
typedef struct packed {
	logic shift;
	logic load;
	logic store;
	logic link;
	logic jump;
	logic branch;
	logic register;
	logic immediate;
} instrCategory;

typedef enum logic {
	P1_RS = 1'b0,
	P1_RT = 1'b1
} port1Src;

typedef enum logic {
	P2_RT = 1'b0,
	P2_RS = 1'b1
} port2Src;

typedef enum logic [1:0] {
	WA_RT  = 2'd0,
	WA_RD  = 2'd1,
	WA_R31 = 2'd2
} writeAddrSrc;

typedef enum logic [1:0] {
	WD_ALU    = 2'd0,
	WD_MEMORY = 2'd1,
	WD_PC     = 2'd2
} writeDataSrc;

typedef struct packed {
	port1Src     port1Source;
	port2Src     port2Source;
	writeAddrSrc writeAddrSource;
	writeDataSrc writeDataSource;
	logic        writeEnable;
} regControl;

typedef struct packed {
	logic [4:0]  port1Addr;
	logic [4:0]  port2Addr;
	logic [4:0]  writeAddr;
	writeDataSrc writeDataSource;
	logic        writeEnable;
	logic [4:0]  shamt; // For the shifter downstream.
} regAccess;

typedef struct packed {
	mipsInstr     instr;
	opFunc        opFunc;
	instrCategory category;
} decodedInstr;

localparam logic [5:0] OP_SPECIAL = 6'h00;
localparam logic [5:0] OP_REGIMM  = 6'h01;
localparam logic [5:0] OP_J       = 6'h02;
localparam logic [5:0] OP_JAL     = 6'h03;
localparam logic [5:0] OP_BEQ     = 6'h04;
localparam logic [5:0] OP_BNE     = 6'h05;
localparam logic [5:0] OP_BLEZ    = 6'h06;
localparam logic [5:0] OP_BGTZ    = 6'h07;
localparam logic [5:0] OP_ADDI    = 6'h08;
localparam logic [5:0] OP_ADDIU   = 6'h09;
localparam logic [5:0] OP_SLTI    = 6'h0A;
localparam logic [5:0] OP_SLTIU   = 6'h0B;
localparam logic [5:0] OP_ANDI    = 6'h0C;
localparam logic [5:0] OP_ORI     = 6'h0D;
localparam logic [5:0] OP_XORI    = 6'h0E;
localparam logic [5:0] OP_LUI     = 6'h0F;
localparam logic [5:0] OP_LB      = 6'h20;
localparam logic [5:0] OP_LH      = 6'h21;
localparam logic [5:0] OP_LWL     = 6'h22;
localparam logic [5:0] OP_LW      = 6'h23;
localparam logic [5:0] OP_LBU     = 6'h24;
localparam logic [5:0] OP_LHU     = 6'h25;
localparam logic [5:0] OP_SB      = 6'h28;
localparam logic [5:0] OP_SH      = 6'h29;
localparam logic [5:0] OP_SW      = 6'h2B;

localparam logic [5:0] FN_SLL  = 6'h00;
localparam logic [5:0] FN_SRL  = 6'h02;
localparam logic [5:0] FN_SRA  = 6'h03;
localparam logic [5:0] FN_SLLV = 6'h04;
localparam logic [5:0] FN_SRLV = 6'h06;
localparam logic [5:0] FN_SRAV = 6'h07;
localparam logic [5:0] FN_JR   = 6'h08;
localparam logic [5:0] FN_JALR = 6'h09;

// REGIMM rt codes that link.
localparam logic [4:0] RT_BLTZAL = 5'd16;
localparam logic [4:0] RT_BGEZAL = 5'd17;

endpackage

//--- hw/mipsRegDecode.sv
module mipsRegDecode #(
	parameter int REG_COUNT = 32
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              instrValid,
	input  mipsPkg::mipsInstr instr,
	input  logic [31:0]       aluResult,
	input  logic [31:0]       memData,
	input  logic [31:0]       linkPc,
	output logic              accessValid,
	output mipsPkg::regAccess access,
	output logic [31:0]       rdData1,
	output logic [31:0]       rdData2
);

import mipsPkg::*;

logic        decValid;
decodedInstr dec;
regControl   ctrl;

instrDecode decode_i (
	.clk        (clk),
	.rst        (rst),
	.instrValid (instrValid),
	.instr      (instr),
	.decValid   (decValid),
	.dec        (dec)
);

regControlGen control_i (
	.category (dec.category),
	.ctrl     (ctrl)
);

regAccessStage access_i (
	.clk         (clk),
	.rst         (rst),
	.decValid    (decValid),
	.instr       (dec.instr),
	.ctrl        (ctrl),
	.accessValid (accessValid),
	.access      (access)
);

regFile #(
	.REG_COUNT (REG_COUNT)
) regFile_i (
	.clk         (clk),
	.rst         (rst),
	.accessValid (accessValid),
	.access      (access),
	.aluResult   (aluResult),
	.memData     (memData),
	.linkPc      (linkPc),
	.rdData1     (rdData1),
	.rdData2     (rdData2)
);

endmodule

//--- hw/regAccessStage.sv
module regAccessStage (
	input  logic               clk,
	input  logic               rst,
	input  logic               decValid,
	input  mipsPkg::mipsInstr  instr,
	input  mipsPkg::regControl ctrl,
	output logic               accessValid,
	output mipsPkg::regAccess  access
);

import mipsPkg::*;

logic [4:0] port1Addr;
logic [4:0] port2Addr;
logic [4:0] writeAddr;

always_comb begin
	port1Addr = (ctrl.port1Source == P1_RT) ? instr.rType.rt : instr.rType.rs;
	port2Addr = (ctrl.port2Source == P2_RS) ? instr.rType.rs : instr.rType.rt;
end

always_comb begin
	case (ctrl.writeAddrSource)
		WA_RD:   writeAddr = instr.rType.rd;
		WA_R31:  writeAddr = 5'd31;
		default: writeAddr = instr.rType.rt;
	endcase
end

always_ff @(posedge clk) begin
	if (rst)
		accessValid <= 1'b0;
	else
		accessValid <= decValid;
end

// Access plan held until the next decoded item.
always_ff @(posedge clk) begin
	if (decValid) begin
		access.port1Addr       <= port1Addr;
		access.port2Addr       <= port2Addr;
		access.writeAddr       <= writeAddr;
		access.writeDataSource <= ctrl.writeDataSource;
		access.writeEnable     <= ctrl.writeEnable;
		access.shamt           <= instr.rType.shamt;
	end
end

endmodule

//--- hw/regControlGen.sv
module regControlGen (
	input  mipsPkg::instrCategory category,
	output mipsPkg::regControl    ctrl
);

import mipsPkg::*;

port1Src     port1Source;
port2Src     port2Source;
writeAddrSrc writeAddrSource;
writeDataSrc writeDataSource;
logic        writeEnable;

// Shifts read rt on port 1.
always_comb begin
	if (category.shift)
		port1Source = P1_RT;
	else
		port1Source = P1_RS;
end

always_comb begin
	if (category.shift)
		port2Source = P2_RS;
	else
		port2Source = P2_RT;
end

always_comb begin
	if (category.load)
		writeAddrSource = WA_RT;
	else if (category.link)
		writeAddrSource = WA_R31;
	else if (category.shift || category.register)
		writeAddrSource = WA_RD;
	else
		writeAddrSource = WA_RT; // Immediates and unknown opcodes.
end

always_comb begin
	if (category.load)
		writeDataSource = WD_MEMORY;
	else if (category.link)
		writeDataSource = WD_PC;
	else
		writeDataSource = WD_ALU;
end

// Link wins over jump and branch.
always_comb begin
	if (category.link)
		writeEnable = 1'b1;
	else if (category.jump || category.branch || category.store)
		writeEnable = 1'b0;
	else
		writeEnable = 1'b1;
end

always_comb begin
	ctrl.port1Source     = port1Source;
	ctrl.port2Source     = port2Source;
	ctrl.writeAddrSource = writeAddrSource;
	ctrl.writeDataSource = writeDataSource;
	ctrl.writeEnable     = writeEnable;
end

endmodule

//--- hw/regFile.sv
module regFile #(
	parameter int REG_COUNT = 32
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              accessValid,
	input  mipsPkg::regAccess access,
	input  logic [31:0]       aluResult,
	input  logic [31:0]       memData,
	input  logic [31:0]       linkPc,
	output logic [31:0]       rdData1,
	output logic [31:0]       rdData2
);

import mipsPkg::*;

localparam int ADDR_W = $clog2(REG_COUNT);

logic [31:0]       regs [REG_COUNT];
logic [31:0]       wrData;
logic [ADDR_W-1:0] rdIdx1;
logic [ADDR_W-1:0] rdIdx2;
logic [ADDR_W-1:0] wrIdx;

// Upper address bits drop out for a smaller file.
assign rdIdx1 = access.port1Addr[ADDR_W-1:0];
assign rdIdx2 = access.port2Addr[ADDR_W-1:0];
assign wrIdx  = access.writeAddr[ADDR_W-1:0];

assign rdData1 = (rdIdx1 == '0) ? 32'h0 : regs[rdIdx1];
assign rdData2 = (rdIdx2 == '0) ? 32'h0 : regs[rdIdx2];

always_comb begin
	case (access.writeDataSource)
		WD_MEMORY: wrData = memData;
		WD_PC:     wrData = linkPc;
		default:   wrData = aluResult;
	endcase
end

always_ff @(posedge clk) begin
	if (rst) begin
		for (int i = 0; i < REG_COUNT; i++)
			regs[i] <= 32'h0;
	end else if (accessValid && access.writeEnable && wrIdx != '0) begin
		regs[wrIdx] <= wrData;
	end
end

endmodule

//--- vlog.f
hw/mipsPkg.sv
hw/instrDecode.sv
hw/regControlGen.sv
hw/regAccessStage.sv
hw/regFile.sv
hw/mipsRegDecode.sv
dv/tbClock.sv
dv/mipsRegDecode_assert.sv
dv/tbMipsRegDecode.sv
